// ==== all.f ====
+incdir+.
cfg_ram_pkg.sv
cfg_mem_if.sv
cfg_cpu_fsm.sv
cfg_rdy_timer.sv
cfg_port_mux.sv
cfg_ram_array.sv
cfg_par_check.sv
cfg_ram_top.sv
tb_cfg_ram.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f all.f --top-module tb_cfg_ram -o tb_cfg_ram
./obj_dir/tb_cfg_ram > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
grep -q "sim passed" sim.log

// ==== tb_cfg_ram.sv ====
`timescale 1ns/1ps
`include "cfg_ram_macros.svh"

module tb_cfg_ram
    import cfg_ram_pkg::*;
();

    localparam int WR_RDY  = 8;
    localparam int RD_RDY  = 7;
    localparam int ENG_LAT = `CFG_RD_LAT;

    typedef enum int {
        OP_WR,
        OP_RD,
        OP_BURST,
        OP_GAP,
        OP_CPU_BURST,
        OP_MATCH,
        OP_COLL,
        OP_PAR
    } op_e;

    typedef struct {
        string name;
        op_e   op;
        int    addr;
        int    eaddr;
        int    len;
        logic  pf;
        logic  pd;
        int    exp_val;
    } step_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      eng_re;
    logic      active;
    cfg_addr_t eng_addr;
    logic      cpu_en;
    logic      cpu_wr_stb;
    logic      cpu_rd_stb;
    cfg_addr_t cpu_addr;
    cfg_data_t cpu_wdata;
    logic      par_force;
    logic      par_dis;
    cfg_data_t eng_rdata;
    cfg_data_t cpu_rdata;
    logic      cpu_rdy;
    logic      par_err;

    step_t       steps [$];
    cfg_data_t   shadow [0:(1 << `CFG_ADDR_BITS)-1];
    logic [31:0] lfsr;
    int          cyc = 0;
    int          max_cycles = 1000;
    string       cur_name;
    int          exp_due [$];
    cfg_data_t   exp_dat [$];
    cfg_data_t   last_arr;

    cfg_ram_top uut (
        .clk        (clk),
        .rst        (rst),
        .eng_re     (eng_re),
        .active     (active),
        .eng_addr   (eng_addr),
        .cpu_en     (cpu_en),
        .cpu_wr_stb (cpu_wr_stb),
        .cpu_rd_stb (cpu_rd_stb),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .par_force  (par_force),
        .par_dis    (par_dis),
        .eng_rdata  (eng_rdata),
        .cpu_rdata  (cpu_rdata),
        .cpu_rdy    (cpu_rdy),
        .par_err    (par_err)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_word(output cfg_data_t w);
        w = '0;
        for (int i = 0; i < `CFG_DATA_WIDTH; i++)
        begin
            lfsr = lfsr_next(lfsr);
            w    = {w[`CFG_DATA_WIDTH-2:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) next_cycle();
        rst = 1'b0;
    endtask

    task automatic add_step(input string name, input op_e op, input int addr, input int eaddr,
                            input int len, input logic pf, input logic pd, input int exp_val);
        step_t st;
        st.name    = name;
        st.op      = op;
        st.addr    = addr;
        st.eaddr   = eaddr;
        st.len     = len;
        st.pf      = pf;
        st.pd      = pd;
        st.exp_val = exp_val;
        steps.push_back(st);
    endtask

    // Strobe in the current cycle and wait for the ready pulse
    task automatic cpu_access(input logic wr, input cfg_addr_t addr, input cfg_data_t data,
                              output int lat, output cfg_data_t rdata);
        int t0;
        cpu_addr   = addr;
        cpu_wdata  = data;
        cpu_wr_stb = wr;
        cpu_rd_stb = !wr;
        t0         = cyc;
        next_cycle();
        cpu_wr_stb = 1'b0;
        cpu_rd_stb = 1'b0;
        do
            @(negedge clk);
        while (!cpu_rdy);
        lat   = cyc - t0;
        rdata = cpu_rdata;
    endtask

    // Request with active low returns whatever the array read last
    task automatic eng_burst(input int base, input int stride, input int len, input int gap,
                             input int lat);
        for (int i = 0; i < len; i++)
        begin
            eng_addr = cfg_addr_t'(base + i * stride);
            eng_re   = 1'b1;
            active   = (i != gap);
            if (i != gap)
                last_arr = shadow[eng_addr];
            exp_due.push_back(cyc + lat);
            exp_dat.push_back(last_arr);
            next_cycle();
        end
        eng_re = 1'b0;
        active = 1'b1;
    endtask

    task automatic drain_engine();
        while (exp_due.size() > 0)
            @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Cycle count, timeout and engine data monitor

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc > max_cycles)
        begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cyc);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk)
    begin
        while (exp_due.size() > 0 && exp_due[0] == cyc)
        begin
            check_value(cur_name, exp_dat[0], eng_rdata);
            void'(exp_due.pop_front());
            void'(exp_dat.pop_front());
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    initial
    begin
        int        lat;
        cfg_data_t w;
        cfg_data_t rd;
        step_t     st;

        rst        = 1'b1;
        eng_re     = 1'b0;
        active     = 1'b0;
        eng_addr   = '0;
        cpu_en     = 1'b0;
        cpu_wr_stb = 1'b0;
        cpu_rd_stb = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        par_force  = 1'b0;
        par_dis    = 1'b0;
        last_arr   = '0;
        lfsr       = 32'd96810;

        // name, op, CPU addr, engine addr, length, par_force, par_dis, expected
        add_step("wr_single",     OP_WR,        3,  0,  1, 1'b0, 1'b0, WR_RDY);
        add_step("rd_single",     OP_RD,        3,  0,  1, 1'b0, 1'b0, RD_RDY);
        add_step("wr_fill",       OP_WR,        8,  0,  8, 1'b0, 1'b0, WR_RDY);
        add_step("rd_fill",       OP_RD,        8,  0,  8, 1'b0, 1'b0, RD_RDY);
        add_step("eng_burst",     OP_BURST,     0,  8,  8, 1'b0, 1'b0, ENG_LAT);
        add_step("eng_gap",       OP_GAP,       0,  8,  6, 1'b0, 1'b0, ENG_LAT);
        add_step("cpu_rd_wait",   OP_CPU_BURST, 3,  8,  6, 1'b0, 1'b0, 6);
        add_step("cpu_rd_match",  OP_MATCH,     10, 10, 4, 1'b0, 1'b0, RD_RDY);
        add_step("collision",     OP_COLL,      12, 12, 1, 1'b0, 1'b0, ENG_LAT);
        add_step("rd_after_coll", OP_RD,        12, 0,  1, 1'b0, 1'b0, RD_RDY);
        add_step("par_force",     OP_PAR,       20, 0,  1, 1'b1, 1'b0, 1);
        add_step("par_dis",       OP_PAR,       21, 0,  1, 1'b1, 1'b1, 0);
        max_cycles = steps.size() * 20 + 200;

        apply_reset();
        cpu_en = 1'b1;
        active = 1'b1;

        foreach (steps[s])
        begin
            st       = steps[s];
            cur_name = st.name;
            next_cycle();
            case (st.op)
                OP_WR:
                begin
                    for (int i = 0; i < st.len; i++)
                    begin
                        rand_word(w);
                        cpu_access(1'b1, cfg_addr_t'(st.addr + i), w, lat, rd);
                        check_value(st.name, st.exp_val, lat);
                        shadow[st.addr + i] = w;
                        next_cycle();
                    end
                end
                OP_RD:
                begin
                    for (int i = 0; i < st.len; i++)
                    begin
                        cpu_access(1'b0, cfg_addr_t'(st.addr + i), '0, lat, rd);
                        check_value(st.name, st.exp_val, lat);
                        check_value(st.name, shadow[st.addr + i], rd);
                        next_cycle();
                    end
                end
                OP_BURST, OP_GAP:
                begin
                    eng_burst(st.eaddr, 1, st.len, (st.op == OP_GAP) ? st.len / 2 : -1,
                              st.exp_val);
                    drain_engine();
                end
                OP_CPU_BURST, OP_MATCH:
                begin
                    fork
                        eng_burst(st.eaddr, (st.op == OP_MATCH) ? 0 : 1, st.len, -1, ENG_LAT);
                        cpu_access(1'b0, cfg_addr_t'(st.addr), '0, lat, rd);
                    join
                    // Blocked read is granted in the first idle cycle after the burst
                    check_value(st.name, (st.op == OP_MATCH) ? st.exp_val : st.len + st.exp_val,
                                lat);
                    check_value(st.name, shadow[st.addr], rd);
                    drain_engine();
                end
                OP_COLL:
                begin
                    rand_word(w);
                    fork
                        cpu_access(1'b1, cfg_addr_t'(st.addr), w, lat, rd);
                        begin
                            // Engine read in the mem_we cycle of the write
                            next_cycle();
                            next_cycle();
                            eng_addr = cfg_addr_t'(st.addr);
                            eng_re   = 1'b1;
                            exp_due.push_back(cyc + st.exp_val);
                            exp_dat.push_back(w);
                            next_cycle();
                            eng_re = 1'b0;
                        end
                    join
                    check_value(st.name, WR_RDY, lat);
                    shadow[st.addr] = w;
                    drain_engine();
                end
                OP_PAR:
                begin
                    apply_reset();
                    par_force = st.pf;
                    par_dis   = st.pd;
                    rand_word(w);
                    cpu_access(1'b1, cfg_addr_t'(st.addr), w, lat, rd);
                    check_value(st.name, WR_RDY, lat);
                    shadow[st.addr] = w;
                    next_cycle();
                    par_force = 1'b0;
                    cpu_access(1'b0, cfg_addr_t'(st.addr), '0, lat, rd);
                    check_value(st.name, RD_RDY, lat);
                    check_value(st.name, w, rd);
                    // Flag rises one cycle after ready and holds
                    @(negedge clk);
                    check_value(st.name, st.exp_val, {31'b0, par_err});
                    repeat (10) @(negedge clk);
                    check_value(st.name, st.exp_val, {31'b0, par_err});
                    next_cycle();
                    par_dis = 1'b0;
                end
                default:
                begin
                end
            endcase
            if (st.op != OP_PAR)
                check_value(st.name, 32'd0, {31'b0, par_err});
        end

        drain_engine();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== cfg_ram_top.sv ====
`timescale 1ns/1ps
`include "cfg_ram_macros.svh"

module cfg_ram_top
    import cfg_ram_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      eng_re,
    input  logic      active,
    input  cfg_addr_t eng_addr,
    input  logic      cpu_en,
    input  logic      cpu_wr_stb,
    input  logic      cpu_rd_stb,
    input  cfg_addr_t cpu_addr,
    input  cfg_data_t cpu_wdata,
    input  logic      par_force,
    input  logic      par_dis,
    output cfg_data_t eng_rdata,
    output cfg_data_t cpu_rdata,
    output logic      cpu_rdy,
    output logic      par_err
);

    logic       wr_go;
    logic       rd_grant;
    logic       rdy_start;
    logic       eng_busy_other;
    cpu_state_t cpu_state;

    cfg_mem_if mem_if ();

    cfg_cpu_fsm u_cpu_fsm (
        .clk            (clk),
        .rst            (rst),
        .cpu_en         (cpu_en),
        .cpu_wr_stb     (cpu_wr_stb),
        .cpu_rd_stb     (cpu_rd_stb),
        .eng_busy_other (eng_busy_other),
        .rdy_done       (cpu_rdy),
        .wr_go          (wr_go),
        .rd_grant       (rd_grant),
        .rdy_start      (rdy_start),
        .state          (cpu_state)
    );

    // Timer only runs while an access is open
    cfg_rdy_timer u_rdy_timer (
        .clk   (clk),
        .rst   (rst),
        .start (rdy_start),
        .abort (!cpu_en || (cpu_state == CPU_IDLE)),
        .done  (cpu_rdy)
    );

    cfg_port_mux u_port_mux (
        .clk            (clk),
        .rst            (rst),
        .eng_re         (eng_re),
        .active         (active),
        .eng_addr       (eng_addr),
        .cpu_en         (cpu_en),
        .cpu_addr       (cpu_addr),
        .cpu_wdata      (cpu_wdata),
        .wr_go          (wr_go),
        .rd_grant       (rd_grant),
        .par_force      (par_force),
        .eng_busy_other (eng_busy_other),
        .eng_rdata      (eng_rdata),
        .cpu_rdata      (cpu_rdata),
        .mem            (mem_if.port)
    );

    cfg_ram_array u_ram_array (
        .clk (clk),
        .rst (rst),
        .mem (mem_if.array)
    );

    cfg_par_check u_par_check (
        .clk     (clk),
        .rst     (rst),
        .mem_re  (mem_if.mem_re),
        .mem_rd  (mem_if.mem_rd),
        .par_dis (par_dis),
        .par_err (par_err)
    );

endmodule

// ==== cfg_par_check.sv ====
`timescale 1ns/1ps
`include "cfg_ram_macros.svh"

module cfg_par_check
    import cfg_ram_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      mem_re,
    input  cfg_word_t mem_rd,
    input  logic      par_dis,
    output logic      par_err
);

    // Read latency plus the capture register below
    localparam int CHK_STAGES = `CFG_RD_LAT + 1;

    logic [CHK_STAGES-1:0] re_pipe;
    cfg_word_t             rd_q;
    logic                  chk_err;

    always_ff @(posedge clk)
    begin
        if (rst)
            re_pipe <= '0;
        else
            re_pipe <= {re_pipe[CHK_STAGES-2:0], mem_re};
    end

    always_ff @(posedge clk)
    begin
        rd_q <= mem_rd;
    end

    // Good word has even parity over data and parity bit
    assign chk_err = !par_dis && re_pipe[CHK_STAGES-1] && (^rd_q);

    // Sticky until reset
    always_ff @(posedge clk)
    begin
        if (rst)
            par_err <= 1'b0;
        else
            par_err <= par_err | chk_err;
    end

endmodule

// ==== cfg_ram_array.sv ====
`timescale 1ns/1ps
`include "cfg_ram_macros.svh"

module cfg_ram_array
    import cfg_ram_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    cfg_mem_if.array mem
);

    localparam int DEPTH = 1 << `CFG_ADDR_BITS;

    cfg_word_t storage [0:DEPTH-1];
    cfg_word_t rd_pipe [0:`CFG_RD_LAT-1];

    always_ff @(posedge clk)
    begin
        if (mem.mem_we)
            storage[mem.mem_wa] <= mem.mem_wd;
    end

    // First stage is the RAM read, the rest model the output pipeline
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CFG_RD_LAT; i++)
                rd_pipe[i] <= '0;
        end
        else
        begin
            if (mem.mem_re)
                rd_pipe[0] <= storage[mem.mem_ra];
            for (int i = 1; i < `CFG_RD_LAT; i++)
                rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign mem.mem_rd = rd_pipe[`CFG_RD_LAT-1];

endmodule

// ==== cfg_port_mux.sv ====
`timescale 1ns/1ps
`include "cfg_ram_macros.svh"

module cfg_port_mux
    import cfg_ram_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      eng_re,
    input  logic      active,
    input  cfg_addr_t eng_addr,
    input  logic      cpu_en,
    input  cfg_addr_t cpu_addr,
    input  cfg_data_t cpu_wdata,
    input  logic      wr_go,
    input  logic      rd_grant,
    input  logic      par_force,
    output logic      eng_busy_other,
    output cfg_data_t eng_rdata,
    output cfg_data_t cpu_rdata,
    cfg_mem_if.port   mem
);

    logic                   eng_rd;
    logic                   rd_req;
    cfg_addr_t              rd_addr;
    logic                   wr_hit;
    logic                   wr_par;
    logic [`CFG_RD_LAT-1:0] byp_pipe;
    cfg_data_t              cpu_rd_q;

    ////////////////////////////////////////////////////////////////////////////
    // Read port, engine first

    assign eng_rd  = eng_re & active;
    assign rd_req  = eng_rd | rd_grant;
    assign rd_addr = eng_rd ? eng_addr : cpu_addr;

    // CPU read may share an engine read of the same word
    assign eng_busy_other = eng_rd && (eng_addr != cpu_addr);

    ////////////////////////////////////////////////////////////////////////////
    // Write port

    // cpu_wdata is held until ready, one register is enough
    always_ff @(posedge clk)
    begin
        wr_par <= (^cpu_wdata) ^ par_force;
    end

    assign mem.mem_we = wr_go;
    assign mem.mem_wa = cpu_addr;
    assign mem.mem_wd = {wr_par, cpu_wdata};

    // Read to the word being written this cycle skips the array
    assign wr_hit     = wr_go && (cpu_addr == rd_addr);
    assign mem.mem_re = rd_req & ~wr_hit;
    assign mem.mem_ra = rd_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Bypass tracking and read data return

    always_ff @(posedge clk)
    begin
        if (rst)
            byp_pipe <= '0;
        else
            byp_pipe <= {byp_pipe[`CFG_RD_LAT-2:0], rd_req & wr_hit};
    end

    // Write data still stable here, ready comes one cycle later
    assign eng_rdata = byp_pipe[`CFG_RD_LAT-1] ? cpu_wdata
                                               : mem.mem_rd[`CFG_DATA_WIDTH-1:0];

    // One more stage lines cpu_rdata up with cpu_rdy
    always_ff @(posedge clk)
    begin
        cpu_rd_q <= eng_rdata;
    end

    assign cpu_rdata = cpu_en ? cpu_rd_q : '0;

endmodule

// ==== cfg_rdy_timer.sv ====
`timescale 1ns/1ps
`include "cfg_ram_macros.svh"

module cfg_rdy_timer
    import cfg_ram_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic abort,
    output logic done
);

    localparam int CNT_W = $clog2(`CFG_RDY_DLY);

    logic [CNT_W-1:0] cnt;

    // Registered done, so the pulse lands CFG_RDY_DLY cycles after start
    always_ff @(posedge clk)
    begin
        if (rst || abort)
        begin
            cnt  <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= (cnt == CNT_W'(1));
            if (start)
                cnt <= CNT_W'(`CFG_RDY_DLY - 1);
            else if (cnt != '0)
                cnt <= cnt - 1'b1;
        end
    end

endmodule

// ==== cfg_cpu_fsm.sv ====
`timescale 1ns/1ps
`include "cfg_ram_macros.svh"

module cfg_cpu_fsm
    import cfg_ram_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_en,
    input  logic       cpu_wr_stb,
    input  logic       cpu_rd_stb,
    input  logic       eng_busy_other,
    input  logic       rdy_done,
    output logic       wr_go,
    output logic       rd_grant,
    output logic       rdy_start,
    output cpu_state_t state
);

    cpu_state_t state_nxt;
    logic       wr_go_q;

    ////////////////////////////////////////////////////////////////////////////
    // Next state

    always_comb
    begin
        state_nxt = state;
        if (!cpu_en)
        begin
            // Enable drop aborts whatever is in progress
            state_nxt = CPU_IDLE;
        end
        else
        begin
            case (state)
                CPU_IDLE:
                begin
                    if (cpu_wr_stb)
                        state_nxt = CPU_WR_DLY;
                    else if (cpu_rd_stb)
                        state_nxt = CPU_RD_PEND;
                end
                CPU_WR_DLY:
                    state_nxt = CPU_WAIT_RDY;
                CPU_RD_PEND:
                begin
                    if (!eng_busy_other)
                        state_nxt = CPU_WAIT_RDY;
                end
                CPU_WAIT_RDY:
                begin
                    if (rdy_done)
                        state_nxt = CPU_IDLE;
                end
                default:
                    state_nxt = CPU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= CPU_IDLE;
            wr_go_q <= 1'b0;
        end
        else
        begin
            state   <= state_nxt;
            // Write lands two cycles after its strobe
            wr_go_q <= cpu_en && (state == CPU_WR_DLY);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs

    assign wr_go     = wr_go_q & cpu_en;
    assign rd_grant  = cpu_en && (state == CPU_RD_PEND) && !eng_busy_other;
    assign rdy_start = wr_go | rd_grant;

endmodule

// ==== cfg_mem_if.sv ====
`timescale 1ns/1ps
`include "cfg_ram_macros.svh"

interface cfg_mem_if
    import cfg_ram_pkg::*;
();

    // Write port
    logic      mem_we;
    cfg_addr_t mem_wa;
    cfg_word_t mem_wd;

    // Read port, data returns CFG_RD_LAT cycles after mem_re
    logic      mem_re;
    cfg_addr_t mem_ra;
    cfg_word_t mem_rd;

    modport port (
        output mem_we, mem_wa, mem_wd,
        output mem_re, mem_ra,
        input  mem_rd
    );

    modport array (
        input  mem_we, mem_wa, mem_wd,
        input  mem_re, mem_ra,
        output mem_rd
    );

endinterface

// ==== cfg_ram_pkg.sv ====
`include "cfg_ram_macros.svh"

package cfg_ram_pkg;

    typedef logic [`CFG_ADDR_BITS-1:0]  cfg_addr_t;
    typedef logic [`CFG_DATA_WIDTH-1:0] cfg_data_t;

    // Parity bit sits above the data bits
    typedef logic [`CFG_DATA_WIDTH:0]   cfg_word_t;

    // One CPU access at a time
    typedef enum logic [1:0] {
        CPU_IDLE,
        CPU_WR_DLY,
        CPU_RD_PEND,
        CPU_WAIT_RDY
    } cpu_state_t;

endpackage

// ==== cfg_ram_macros.svh ====
`ifndef CFG_RAM_MACROS_SVH
`define CFG_RAM_MACROS_SVH

// Table geometry, 32 words
`define CFG_ADDR_BITS  5
`define CFG_DATA_WIDTH 32

// Cycles from RAM read request to data at the array output
`define CFG_RD_LAT     5

// Cycles from a granted CPU access to the ready pulse
`define CFG_RDY_DLY    6

`endif
